//--- sources.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_ctrl_if.sv
hdl/dcache_dpram.sv
hdl/dcache_lru.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, a build or run failure counts as a failed test
verilator --binary --timing --assert -f sources.f --top-module tb_dcache -o tb_dcache \
   > sim.log 2>&1 &&
   ./obj_dir/tb_dcache >> sim.log 2>&1 ||
   echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST OK" sim.log && ! grep -q "TEST FAILED" sim.log

//--- tests/tb_dcache.sv
// Testbench for dcache_top, needs a simulator with concurrent assertions enabled, memory is a model
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module tb_dcache;

   // Run needs a few hundred cycles, stop well past that
   localparam int MAX_CYCLES = 3000;
   // Ack is sampled on the second edge after the request is driven
   localparam int HIT_EDGES = 2;
   // Edges to wait for an SPR ack before giving up
   localparam int SPR_WAIT = 8;

   logic clk;
   logic rst;
   logic cpu_req;
   logic cpu_we;
   dcache_pkg::addr_t cpu_adr;
   dcache_pkg::word_t cpu_dat;
   dcache_pkg::bsel_t cpu_bsel;
   logic cpu_ack;
   dcache_pkg::word_t cpu_rdat;
   logic refill_req;
   dcache_pkg::addr_t refill_adr;
   dcache_pkg::word_t refill_dat;
   logic refill_we;
   logic refill_done;
   logic spr_stb;
   logic spr_we;
   logic [15:0] spr_addr;
   dcache_pkg::word_t spr_dat;
   logic spr_ack;

   // Words changed by stores, everything else follows the address pattern
   dcache_pkg::word_t mem_override [dcache_pkg::addr_t];
   dcache_pkg::word_t exp_dat;
   logic expect_hit;
   int cycle_count;
   int done_count;
   int beat_cnt;
   int seed;
   // One counter per checker
   int ack_errors;
   int data_errors;
   int refill_errors;
   int check_errors;
   int test_count;
   int pass_count;

   dcache_top i_dcache_top (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req),
      .cpu_we_i       (cpu_we),
      .cpu_adr_i      (cpu_adr),
      .cpu_dat_i      (cpu_dat),
      .cpu_bsel_i     (cpu_bsel),
      .cpu_ack_o      (cpu_ack),
      .cpu_dat_o      (cpu_rdat),
      .refill_req_o   (refill_req),
      .refill_adr_i   (refill_adr),
      .refill_dat_i   (refill_dat),
      .refill_we_i    (refill_we),
      .refill_done_o  (refill_done),
      .spr_bus_stb_i  (spr_stb),
      .spr_bus_we_i   (spr_we),
      .spr_bus_addr_i (spr_addr),
      .spr_bus_dat_i  (spr_dat),
      .spr_bus_ack_o  (spr_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Memory word, address pattern unless a store changed it
   function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t adr);
      dcache_pkg::addr_t wadr;
      wadr = {adr[`DC_ADDR_WIDTH-1:2], 2'b00};
      if (mem_override.exists(wadr)) begin
         return mem_override[wadr];
      end
      return wadr ^ 32'hA5A5_0000;
   endfunction

   // Selected bytes from the new word, the rest from the old one
   function automatic dcache_pkg::word_t byte_merge(input dcache_pkg::word_t old_w,
                                                    input dcache_pkg::word_t new_w,
                                                    input dcache_pkg::bsel_t sel);
      dcache_pkg::word_t res;
      for (int b = 0; b < 4; b++) begin
         res[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic int total_errors();
      return ack_errors + data_errors + refill_errors + check_errors;
   endfunction

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Refill responder, four wrapped words from the missed one, then wait for req to drop
   always @(posedge clk) begin : responder
      dcache_pkg::word_idx_t widx;
      dcache_pkg::addr_t beat_adr;
      if (rst) begin
         refill_we <= 1'b0;
         beat_cnt <= 0;
      end else if (refill_req && (beat_cnt < 4)) begin
         widx = cpu_adr[`DC_BLOCK_WIDTH-1:2] + dcache_pkg::word_idx_t'(beat_cnt);
         beat_adr = {cpu_adr[`DC_ADDR_WIDTH-1:`DC_BLOCK_WIDTH], widx, 2'b00};
         refill_we <= 1'b1;
         refill_adr <= beat_adr;
         refill_dat <= mem_word(beat_adr);
         beat_cnt <= beat_cnt + 1;
      end else begin
         refill_we <= 1'b0;
         if (!refill_req) begin
            beat_cnt <= 0;
         end
      end
   end

   always @(posedge clk) begin
      if (!rst && refill_done) begin
         done_count <= done_count + 1;
      end
   end

   ack_with_req: assert property (@(posedge clk) disable iff (rst) cpu_ack |-> cpu_req)
      else begin
         ack_errors = ack_errors + 1;
         $display("[ERROR] %0t: cpu_ack_o high without a request", $time);
      end

   read_data: assert property (@(posedge clk) disable iff (rst)
                               (cpu_ack && !cpu_we) |-> (cpu_rdat == exp_dat))
      else begin
         data_errors = data_errors + 1;
         $display("[ERROR] %0t: read data %08h, expected %08h", $time,
                  $sampled(cpu_rdat), $sampled(exp_dat));
      end

   hit_no_refill: assert property (@(posedge clk) disable iff (rst)
                                   (cpu_req && expect_hit) |-> !refill_req)
      else begin
         refill_errors = refill_errors + 1;
         $display("[ERROR] %0t: refill_req_o high during an expected hit", $time);
      end

   task automatic check_cond(input logic cond, input string msg);
      assert (cond) else begin
         check_errors = check_errors + 1;
         $display("[ERROR] %0t: %s", $time, msg);
      end
   endtask

   // One CPU request held until ack, returns the edges waited
   task automatic cpu_access(input logic we, input dcache_pkg::addr_t adr,
                             input dcache_pkg::word_t dat, input dcache_pkg::bsel_t sel,
                             input logic hit, output int latency);
      @(posedge clk);
      cpu_req <= 1'b1;
      cpu_we <= we;
      cpu_adr <= adr;
      cpu_dat <= dat;
      cpu_bsel <= sel;
      exp_dat <= mem_word(adr);
      expect_hit <= hit;
      latency = 0;
      do begin
         @(posedge clk);
         latency = latency + 1;
      end while (!cpu_ack);
      cpu_req <= 1'b0;
      cpu_we <= 1'b0;
      expect_hit <= 1'b0;
      // Write-through, memory takes every store
      if (we) begin
         mem_override[{adr[`DC_ADDR_WIDTH-1:2], 2'b00}] = byte_merge(mem_word(adr), dat, sel);
      end
   endtask

   task automatic read_check(input dcache_pkg::addr_t adr, input logic hit);
      int lat;
      int done_before;
      done_before = done_count;
      cpu_access(1'b0, adr, '0, '0, hit, lat);
      if (hit) begin
         check_cond((lat == HIT_EDGES) && (done_count == done_before),
                    $sformatf("read of %08h did not hit", adr));
      end else begin
         check_cond((lat > HIT_EDGES) && (done_count == done_before + 1),
                    $sformatf("read of %08h did not refill exactly once", adr));
      end
   endtask

   // Stores never refill, hit or miss
   task automatic store_check(input dcache_pkg::addr_t adr);
      int lat;
      int done_before;
      logic [31:0] rnd_dat;
      logic [31:0] rnd_sel;
      done_before = done_count;
      rnd_dat = $random(seed);
      rnd_sel = $random(seed);
      cpu_access(1'b1, adr, rnd_dat, rnd_sel[3:0], 1'b1, lat);
      check_cond((lat == HIT_EDGES) && (done_count == done_before),
                 $sformatf("store to %08h was not acknowledged at once", adr));
   endtask

   task automatic spr_write(input logic [15:0] addr, input dcache_pkg::word_t dat,
                            input logic ack_expected);
      int waited;
      logic got_ack;
      @(posedge clk);
      spr_stb <= 1'b1;
      spr_we <= 1'b1;
      spr_addr <= addr;
      spr_dat <= dat;
      waited = 0;
      do begin
         @(posedge clk);
         waited = waited + 1;
         got_ack = spr_ack;
      end while (!got_ack && (waited < SPR_WAIT));
      spr_stb <= 1'b0;
      spr_we <= 1'b0;
      check_cond(got_ack == ack_expected,
                 $sformatf("SPR write to %04h: ack was %0b, expected %0b",
                           addr, got_ack, ack_expected));
   endtask

   // Half a cycle later so assertion actions of the last edge are counted
   task automatic report_test(input string name, input int errors_before);
      int new_errors;
      @(negedge clk);
      new_errors = total_errors() - errors_before;
      test_count = test_count + 1;
      if (new_errors == 0) begin
         pass_count = pass_count + 1;
      end
      $display("Test %0d %s finished with %0d errors", test_count, name, new_errors);
   endtask

   initial begin
      int errs;
      rst = 1'b1;
      cpu_req = 1'b0;
      cpu_we = 1'b0;
      cpu_adr = '0;
      cpu_dat = '0;
      cpu_bsel = '0;
      refill_adr = '0;
      refill_dat = '0;
      refill_we = 1'b0;
      spr_stb = 1'b0;
      spr_we = 1'b0;
      spr_addr = '0;
      spr_dat = '0;
      exp_dat = '0;
      expect_hit = 1'b0;
      cycle_count = 0;
      done_count = 0;
      seed = 32'h5bde;
      ack_errors = 0;
      data_errors = 0;
      refill_errors = 0;
      check_errors = 0;
      test_count = 0;
      pass_count = 0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // Tags are unknown after reset, clear every set first
      errs = total_errors();
      for (int s = 0; s < 16; s++) begin
         spr_write(`DC_SPR_DCBIR_ADDR, s << `DC_BLOCK_WIDTH, 1'b1);
      end
      read_check(32'h0001_0024, 1'b0);
      report_test("invalidate all and first refill", errs);

      errs = total_errors();
      read_check(32'h0001_0024, 1'b1);
      read_check(32'h0001_0020, 1'b1);
      read_check(32'h0001_0028, 1'b1);
      read_check(32'h0001_002C, 1'b1);
      report_test("hits in the refilled block", errs);

      errs = total_errors();
      store_check(32'h0001_0028);
      read_check(32'h0001_0028, 1'b1);
      // Uncached store, the later refill must bring the stored bytes
      store_check(32'h0002_0054);
      read_check(32'h0002_0054, 1'b0);
      report_test("store hit merge and store miss", errs);

      // Set 7, A in way 1 and B in way 0, then C must evict B
      errs = total_errors();
      read_check(32'h0010_0070, 1'b0);
      read_check(32'h0020_0070, 1'b0);
      read_check(32'h0010_0070, 1'b1);
      read_check(32'h0030_0070, 1'b0);
      read_check(32'h0010_0070, 1'b1);
      read_check(32'h0020_0070, 1'b0);
      report_test("LRU victim choice", errs);

      errs = total_errors();
      spr_write(`DC_SPR_DCBIR_ADDR, 32'h0001_0020, 1'b1);
      read_check(32'h0001_0024, 1'b0);
      spr_write(`DC_SPR_DCBFR_ADDR, 32'h0010_0070, 1'b1);
      read_check(32'h0010_0070, 1'b0);
      // Unrelated SPR is ignored and leaves the block cached
      spr_write(16'h2004, 32'h0001_0020, 1'b0);
      read_check(32'h0001_0024, 1'b1);
      report_test("SPR invalidate and flush", errs);

      @(negedge clk);
      $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
               test_count, pass_count, test_count - pass_count, total_errors());
      if (total_errors() == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- hdl/dcache_top.sv
// Write-through data cache top, memory writes for stores are issued outside the cache
`timescale 1ns/1ns

module dcache_top (
   input  logic               clk,
   input  logic               rst,
   // CPU side
   input  logic               cpu_req_i,
   input  logic               cpu_we_i,
   input  dcache_pkg::addr_t  cpu_adr_i,
   input  dcache_pkg::word_t  cpu_dat_i,
   input  dcache_pkg::bsel_t  cpu_bsel_i,
   output logic               cpu_ack_o,
   output dcache_pkg::word_t  cpu_dat_o,
   // Refill side
   output logic               refill_req_o,
   input  dcache_pkg::addr_t  refill_adr_i,
   input  dcache_pkg::word_t  refill_dat_i,
   input  logic               refill_we_i,
   output logic               refill_done_o,
   // SPR side
   input  logic               spr_bus_stb_i,
   input  logic               spr_bus_we_i,
   input  logic [15:0]        spr_bus_addr_i,
   input  dcache_pkg::word_t  spr_bus_dat_i,
   output logic               spr_bus_ack_o
);

   dcache_ctrl_if i_ctrl_bus ();

   dcache_ctrl i_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .refill_adr_i   (refill_adr_i),
      .refill_we_i    (refill_we_i),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .cpu_ack_o      (cpu_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_done_o  (refill_done_o),
      .spr_bus_ack_o  (spr_bus_ack_o),
      .bus            (i_ctrl_bus.ctrl)
   );

   dcache_tag_store i_tag_store (
      .clk          (clk),
      .rst          (rst),
      .cpu_adr_i    (cpu_adr_i),
      .refill_adr_i (refill_adr_i),
      .bus          (i_ctrl_bus.tags)
   );

   dcache_data_store i_data_store (
      .clk          (clk),
      .cpu_adr_i    (cpu_adr_i),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_bsel_i   (cpu_bsel_i),
      .refill_adr_i (refill_adr_i),
      .refill_dat_i (refill_dat_i),
      .bus          (i_ctrl_bus.data),
      .cpu_dat_o    (cpu_dat_o)
   );

endmodule

//--- hdl/dcache_ctrl.sv
// Cache FSM, CPU must hold request fields until ack and refill words must stay inside the missed block
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               cpu_req_i,
   input  logic               cpu_we_i,
   input  dcache_pkg::addr_t  cpu_adr_i,
   input  dcache_pkg::addr_t  refill_adr_i,
   input  logic               refill_we_i,
   input  logic               spr_bus_stb_i,
   input  logic               spr_bus_we_i,
   input  logic [15:0]        spr_bus_addr_i,
   input  dcache_pkg::word_t  spr_bus_dat_i,
   output logic               cpu_ack_o,
   output logic               refill_req_o,
   output logic               refill_done_o,
   output logic               spr_bus_ack_o,
   dcache_ctrl_if.ctrl        bus
);

   dcache_pkg::ctrl_state_e state;
   // One bit per word of the block being refilled
   logic [2**(`DC_BLOCK_WIDTH-2)-1:0] refill_valid;
   dcache_pkg::word_idx_t refill_word;
   dcache_pkg::word_idx_t next_word;
   logic invalidate;
   logic accept;
   logic miss;
   logic refill_done;

   // Flush and invalidate behave the same here
   assign invalidate = spr_bus_stb_i && spr_bus_we_i &&
                       ((spr_bus_addr_i == `DC_SPR_DCBFR_ADDR) ||
                        (spr_bus_addr_i == `DC_SPR_DCBIR_ADDR));

   // Invalidate wins over a CPU request in IDLE
   assign accept = (state == dcache_pkg::IDLE) && cpu_req_i && !invalidate;
   // Only reads refill, a store miss just acks
   assign miss = (state == dcache_pkg::LOOKUP) && cpu_req_i && !cpu_we_i && !bus.hit;

   // Wrapped order, done once the following word is already in
   assign refill_word = refill_adr_i[`DC_BLOCK_WIDTH-1:2];
   assign next_word = refill_word + 1'b1;
   assign refill_done = (state == dcache_pkg::REFILL) && refill_we_i && refill_valid[next_word];

   assign cpu_ack_o = (state == dcache_pkg::LOOKUP) && cpu_req_i && (bus.hit || cpu_we_i);
   assign refill_req_o = miss || (state == dcache_pkg::REFILL);
   assign refill_done_o = refill_done;
   assign spr_bus_ack_o = invalidate &&
                          ((state == dcache_pkg::IDLE) || (state == dcache_pkg::INVALIDATE));

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= dcache_pkg::IDLE;
         refill_valid <= '0;
      end else begin
         case (state)
            dcache_pkg::IDLE: begin
               if (invalidate) begin
                  state <= dcache_pkg::INVALIDATE;
               end else if (cpu_req_i) begin
                  state <= dcache_pkg::LOOKUP;
               end
            end
            dcache_pkg::LOOKUP: begin
               if (miss) begin
                  refill_valid <= '0;
                  state <= dcache_pkg::REFILL;
               end else begin
                  state <= dcache_pkg::IDLE;
               end
            end
            dcache_pkg::REFILL: begin
               if (refill_we_i) begin
                  refill_valid[refill_word] <= 1'b1;
                  // Back to IDLE, the held request then hits
                  if (refill_done) begin
                     state <= dcache_pkg::IDLE;
                  end
               end
            end
            dcache_pkg::INVALIDATE: begin
               // Stay while further invalidates arrive back to back
               if (!invalidate) begin
                  state <= dcache_pkg::IDLE;
               end
            end
            default: begin
               state <= dcache_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bus.lookup_adr <= cpu_adr_i;
      end
      // SPR data carries the block address, only its set bits matter
      if (spr_bus_ack_o) begin
         bus.inval_set <= spr_bus_dat_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
      end
      // Freeze the victim before the refill changes the LRU
      if (miss) begin
         bus.victim <= bus.lru_victim;
      end
   end

   assign bus.refill_sel = (state == dcache_pkg::REFILL);

   // Tag operations and way write enables per state
   always_comb begin
      bus.tag_op = dcache_pkg::TAG_NONE;
      bus.way_we = '0;
      case (state)
         dcache_pkg::LOOKUP: begin
            if (cpu_req_i && bus.hit) begin
               bus.tag_op = dcache_pkg::TAG_LRU;
               if (cpu_we_i) begin
                  bus.way_we = bus.way_hit;
               end
            end
         end
         dcache_pkg::REFILL: begin
            if (refill_we_i) begin
               bus.way_we = bus.victim;
               // First word drops the old block, last word tags the new one
               if (refill_done) begin
                  bus.tag_op = dcache_pkg::TAG_FILL_VICTIM;
               end else if (refill_valid == '0) begin
                  bus.tag_op = dcache_pkg::TAG_CLEAR_VICTIM;
               end
            end
         end
         dcache_pkg::INVALIDATE: begin
            bus.tag_op = dcache_pkg::TAG_INVAL;
         end
         default: begin
            bus.tag_op = dcache_pkg::TAG_NONE;
         end
      endcase
   end

endmodule

//--- hdl/dcache_data_store.sv
// Way RAMs read at the live CPU address, stores write only the ways the controller enables
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_data_store (
   input  logic               clk,
   input  dcache_pkg::addr_t  cpu_adr_i,
   input  dcache_pkg::word_t  cpu_dat_i,
   input  dcache_pkg::bsel_t  cpu_bsel_i,
   input  dcache_pkg::addr_t  refill_adr_i,
   input  dcache_pkg::word_t  refill_dat_i,
   dcache_ctrl_if.data        bus,
   output dcache_pkg::word_t  cpu_dat_o
);

   dcache_pkg::word_t way_dout [`DC_WAYS];
   dcache_pkg::word_t merge_dat;
   dcache_pkg::word_t way_din;
   dcache_pkg::way_addr_t way_raddr;
   dcache_pkg::way_addr_t way_waddr;

   assign way_raddr = cpu_adr_i[`DC_WAY_WIDTH-1:2];

   // Refill words land at their own address, stores at the looked-up one
   assign way_waddr = bus.refill_sel ? refill_adr_i[`DC_WAY_WIDTH-1:2] :
                                       bus.lookup_adr[`DC_WAY_WIDTH-1:2];

   // One-hot hit, so OR of the selected ways
   always_comb begin
      cpu_dat_o = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (bus.way_hit[w]) begin
            cpu_dat_o = cpu_dat_o | way_dout[w];
         end
      end
   end

   // Unselected bytes keep the word read on the hit
   always_comb begin
      for (int b = 0; b < $bits(dcache_pkg::bsel_t); b++) begin
         merge_dat[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : cpu_dat_o[8*b +: 8];
      end
   end

   assign way_din = bus.refill_sel ? refill_dat_i : merge_dat;

   for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
      dcache_dpram #(
         .ADDR_WIDTH ($bits(dcache_pkg::way_addr_t)),
         .DATA_WIDTH ($bits(dcache_pkg::word_t))
      ) i_way_ram (
         .clk     (clk),
         .raddr_i (way_raddr),
         .waddr_i (way_waddr),
         .we_i    (bus.way_we[w]),
         .din_i   (way_din),
         .dout_o  (way_dout[w])
      );
   end

endmodule

//--- hdl/dcache_tag_store.sv
// Tag RAM is not cleared by reset, every set must be invalidated before the first lookup
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_tag_store (
   input  logic               clk,
   input  logic               rst,
   input  dcache_pkg::addr_t  cpu_adr_i,
   input  dcache_pkg::addr_t  refill_adr_i,
   dcache_ctrl_if.tags        bus
);

   dcache_pkg::tag_entry_t tag_dout;
   dcache_pkg::tag_entry_t tag_din;
   dcache_pkg::set_t tag_rindex;
   dcache_pkg::set_t tag_windex;
   dcache_pkg::tag_t lookup_tag;
   dcache_pkg::tag_t refill_tag;
   dcache_pkg::ways_t lru_access;
   dcache_pkg::lru_hist_t lru_next;
   logic tag_we;

   // Read runs one cycle ahead of the compare
   assign tag_rindex = cpu_adr_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
   assign lookup_tag = bus.lookup_adr[`DC_ADDR_WIDTH-1:`DC_WAY_WIDTH];
   assign refill_tag = refill_adr_i[`DC_ADDR_WIDTH-1:`DC_WAY_WIDTH];

   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         bus.way_hit[w] = tag_dout.way[w].valid && (tag_dout.way[w].tag == lookup_tag);
      end
   end

   assign bus.hit = |bus.way_hit;

   // Refilled way counts as the access on fill, otherwise the hit way
   assign lru_access = (bus.tag_op == dcache_pkg::TAG_FILL_VICTIM) ? bus.victim : bus.way_hit;

   dcache_lru i_lru (
      .current_i (tag_dout.lru),
      .access_i  (lru_access),
      .update_o  (lru_next),
      .victim_o  (bus.lru_victim)
   );

   // Write index follows the address that owns the operation
   always_comb begin
      case (bus.tag_op)
         dcache_pkg::TAG_LRU:   tag_windex = bus.lookup_adr[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
         dcache_pkg::TAG_INVAL: tag_windex = bus.inval_set;
         default:               tag_windex = refill_adr_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
      endcase
   end

   // New entry starts from the current one, set still addressed by the held request
   always_comb begin
      tag_din = tag_dout;
      case (bus.tag_op)
         dcache_pkg::TAG_LRU: begin
            tag_din.lru = lru_next;
         end
         dcache_pkg::TAG_CLEAR_VICTIM: begin
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (bus.victim[w]) begin
                  tag_din.way[w].valid = 1'b0;
               end
            end
         end
         dcache_pkg::TAG_FILL_VICTIM: begin
            tag_din.lru = lru_next;
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (bus.victim[w]) begin
                  tag_din.way[w].valid = 1'b1;
                  tag_din.way[w].tag = refill_tag;
               end
            end
         end
         dcache_pkg::TAG_INVAL: begin
            tag_din = '0;
         end
         default: begin
            tag_din = tag_dout;
         end
      endcase
   end

   assign tag_we = (bus.tag_op != dcache_pkg::TAG_NONE) && !rst;

   dcache_dpram #(
      .ADDR_WIDTH ($bits(dcache_pkg::set_t)),
      .DATA_WIDTH ($bits(dcache_pkg::tag_entry_t))
   ) i_tag_ram (
      .clk     (clk),
      .raddr_i (tag_rindex),
      .waddr_i (tag_windex),
      .we_i    (tag_we),
      .din_i   (tag_din),
      .dout_o  (tag_dout)
   );

endmodule

//--- hdl/dcache_lru.sv
// Pairwise-age LRU, purely combinational, an all-zero access leaves the history unchanged
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_lru (
   input  dcache_pkg::lru_hist_t current_i,
   input  dcache_pkg::ways_t     access_i,
   output dcache_pkg::lru_hist_t update_o,
   output dcache_pkg::ways_t     victim_o
);

   // older[i][j] high when way i was used before way j
   dcache_pkg::ways_t [`DC_WAYS-1:0] older;

   always_comb begin
      int k;
      k = 0;
      older = '0;
      update_o = current_i;
      // Walk pairs i < j in the same order as the history bits
      for (int i = 0; i < `DC_WAYS; i++) begin
         for (int j = i + 1; j < `DC_WAYS; j++) begin
            older[i][j] = current_i[k];
            older[j][i] = ~current_i[k];
            // Accessed way becomes the newest of its pair
            if (access_i[i]) begin
               update_o[k] = 1'b0;
            end else if (access_i[j]) begin
               update_o[k] = 1'b1;
            end
            k++;
         end
      end
   end

   // Victim is older than every other way, own bit counts as satisfied
   always_comb begin
      for (int v = 0; v < `DC_WAYS; v++) begin
         victim_o[v] = &(older[v] | (dcache_pkg::ways_t'(1) << v));
      end
   end

endmodule

//--- hdl/dcache_dpram.sv
// Single-clock RAM, one read and one write port, no reset so contents are unknown until written
`timescale 1ns/1ns

module dcache_dpram #(
   parameter int ADDR_WIDTH = 6,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Forward a colliding write so the reader never sees stale data
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

//--- hdl/dcache_ctrl_if.sv
// Controller to tag and data store link, all signals are sampled on the cache clock
`timescale 1ns/1ns

interface dcache_ctrl_if;

   // Driven by the controller
   dcache_pkg::addr_t lookup_adr;
   dcache_pkg::set_t inval_set;
   dcache_pkg::tag_op_e tag_op;
   dcache_pkg::ways_t way_we;
   dcache_pkg::ways_t victim;
   logic refill_sel;

   // Driven by the tag store, valid in LOOKUP
   logic hit;
   dcache_pkg::ways_t way_hit;
   dcache_pkg::ways_t lru_victim;

   modport ctrl (
      output lookup_adr, inval_set, tag_op, way_we, victim, refill_sel,
      input hit, way_hit, lru_victim
   );

   modport tags (
      input lookup_adr, inval_set, tag_op, victim,
      output hit, way_hit, lru_victim
   );

   modport data (
      input lookup_adr, way_we, refill_sel, way_hit
   );

endinterface

//--- hdl/dcache_pkg.sv
// Cache types sized from dcache_cfg.svh, the tag entry layout is LRU first then one field per way
`include "dcache_cfg.svh"

package dcache_pkg;

   typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`DC_ADDR_WIDTH-1:0] word_t;
   typedef logic [`DC_ADDR_WIDTH/8-1:0] bsel_t;
   typedef logic [`DC_ADDR_WIDTH-`DC_WAY_WIDTH-1:0] tag_t;
   typedef logic [`DC_SET_WIDTH-1:0] set_t;
   typedef logic [`DC_BLOCK_WIDTH-3:0] word_idx_t;
   // Set and word together
   typedef logic [`DC_WAY_WIDTH-3:0] way_addr_t;
   typedef logic [`DC_WAYS-1:0] ways_t;
   typedef logic [`DC_LRU_WIDTH-1:0] lru_hist_t;

   // Valid flag above the stored tag
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_way_t;

   typedef struct packed {
      lru_hist_t lru;
      tag_way_t [`DC_WAYS-1:0] way;
   } tag_entry_t;

   typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, INVALIDATE} ctrl_state_e;

   typedef enum logic [2:0] {
      TAG_NONE,
      TAG_LRU,
      TAG_CLEAR_VICTIM,
      TAG_FILL_VICTIM,
      TAG_INVAL
   } tag_op_e;

endpackage

//--- hdl/dcache_cfg.svh
// Cache geometry and SPR addresses, address width equals data width, DC_WAYS of 1 keeps a 1-bit LRU
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address and data width
`define DC_ADDR_WIDTH 32
// log2 of bytes per block, 4 gives four-word blocks
`define DC_BLOCK_WIDTH 4
// log2 of number of sets
`define DC_SET_WIDTH 4
`define DC_WAYS 2

// Byte address span of one way
`define DC_WAY_WIDTH (`DC_SET_WIDTH + `DC_BLOCK_WIDTH)
// One pairwise age bit per pair of ways, never below one bit
`define DC_LRU_WIDTH ((`DC_WAYS * (`DC_WAYS - 1) / 2 > 0) ? `DC_WAYS * (`DC_WAYS - 1) / 2 : 1)

// Block flush and block invalidate, both clear the whole set
`define DC_SPR_DCBFR_ADDR 16'h2002
`define DC_SPR_DCBIR_ADDR 16'h2003

`endif
